/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns -j 0
TOP       = icache_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
+incdir+source
source/cache_pkg.sv
source/bus_pkg.sv
source/cache_way.sv
source/lru_table.sv
source/hit_select.sv
source/refill_fsm.sv
source/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

/* source/bus_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package bus_pkg;

	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// beat number within a burst
	typedef logic [$clog2(`CACHE_BURST_BEATS)-1:0] beat_count_t;

endpackage

`default_nettype wire

/* source/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cpu byte address and instruction word
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// 16 words per line and 16 sets
`define CACHE_OFFSET_W 4
`define CACHE_INDEX_W 4

// whatever is left above index, offset and the two byte bits
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W - 2)

`define CACHE_SETS (1 << `CACHE_INDEX_W)
`define CACHE_LINE_WORDS (1 << `CACHE_OFFSET_W)

// one full line per refill
`define CACHE_BURST_BEATS 16
`endif

/* source/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

	// cpu address fields
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// way number and per-way strobes
	typedef logic way_t;
	typedef logic [1:0] way_mask_t;

	// refill sequence
	typedef enum logic [2:0]
	{
		st_idle,
		st_bus_wait,
		st_addr,
		st_data,
		st_settle
	} refill_state_t;

endpackage

`default_nettype wire

/* source/cache_way.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module cache_way
(
	input  logic               clk,
	input  logic               rst_n,
	// lookup side
	input  cache_pkg::index_t  lookup_index,
	input  cache_pkg::offset_t lookup_offset,
	output cache_pkg::tag_t    line_tag,
	output logic               line_valid,
	output bus_pkg::word_t     word,
	// refill side
	input  logic               fill_we,
	input  cache_pkg::index_t  fill_index,
	input  cache_pkg::offset_t fill_offset,
	input  bus_pkg::word_t     fill_data,
	input  logic               fill_done,
	input  cache_pkg::tag_t    fill_tag
);

	logic [`CACHE_SETS-1:0] valid_q;
	cache_pkg::tag_t tag_q [`CACHE_SETS];
	bus_pkg::word_t data_q [`CACHE_SETS][`CACHE_LINE_WORDS];

	// tag and valid come straight out for the compare
	assign line_tag = tag_q[lookup_index];
	assign line_valid = valid_q[lookup_index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
		end
		else if (fill_done)
		begin
			valid_q[fill_index] <= 1'b1;
		end
	end

	// tag lands together with the last beat
	always_ff @(posedge clk)
	begin
		if (fill_done)
		begin
			tag_q[fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_we)
		begin
			data_q[fill_index][fill_offset] <= fill_data;
		end
		// word is ready the cycle after lookup
		word <= data_q[lookup_index][lookup_offset];
	end

endmodule

`default_nettype wire

/* source/hit_select.sv */
`timescale 1ns/1ns
`default_nettype none

module hit_select
(
	input  logic              clk,
	input  logic              rst_n,
	// current lookup
	input  logic              cpu_re,
	input  cache_pkg::tag_t   lookup_tag,
	input  cache_pkg::index_t lookup_index,
	// both ways at the lookup index
	input  cache_pkg::tag_t   way0_tag,
	input  cache_pkg::tag_t   way1_tag,
	input  logic              way0_valid,
	input  logic              way1_valid,
	input  bus_pkg::word_t    way0_word,
	input  bus_pkg::word_t    way1_word,
	input  cache_pkg::way_t   lru_way,
	input  logic              refill_busy,
	// to refill
	output logic              miss,
	output cache_pkg::way_t   victim_way,
	// to cpu
	output logic              cpu_stall,
	output bus_pkg::word_t    cpu_rdata,
	// to lru table
	output logic              update_en,
	output cache_pkg::way_t   used_way
);

	logic way0_hit;
	logic way1_hit;
	logic accept;
	logic repeat_hit;
	logic last_valid_q;
	cache_pkg::index_t last_index_q;
	cache_pkg::way_t sel_way_q;

	assign way0_hit = way0_valid && (way0_tag == lookup_tag);
	assign way1_hit = way1_valid && (way1_tag == lookup_tag);

	assign miss = cpu_re && !(way0_hit || way1_hit);
	assign cpu_stall = miss || refill_busy;
	assign accept = cpu_re && !cpu_stall;

	assign used_way = way1_hit;

	// straight-line fetch in one line needs no new lru write
	assign repeat_hit = last_valid_q && (last_index_q == lookup_index) && (sel_way_q == used_way);
	assign update_en = accept && !repeat_hit;

	// empty way first, then the lru choice
	assign victim_way = !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : lru_way);

	assign cpu_rdata = sel_way_q ? way1_word : way0_word;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			last_valid_q <= 1'b0;
		end
		else if (accept)
		begin
			last_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			sel_way_q <= used_way;
			last_index_q <= lookup_index;
		end
	end

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module icache_top
(
	input  logic           clk,
	input  logic           rst_n,
	// cpu side
	input  logic           cpu_re,
	input  bus_pkg::addr_t cpu_addr,
	output logic           cpu_stall,
	output bus_pkg::word_t cpu_rdata,
	// bus side
	output logic           bus_req,
	input  logic           bus_grant,
	output logic           arvalid,
	output bus_pkg::addr_t araddr,
	input  logic           arready,
	input  bus_pkg::word_t rdata,
	input  logic           rvalid,
	output logic           rready
);

	cache_pkg::tag_t cpu_tag;
	cache_pkg::index_t cpu_index;
	cache_pkg::offset_t cpu_offset;

	cache_pkg::tag_t way0_tag;
	cache_pkg::tag_t way1_tag;
	logic way0_valid;
	logic way1_valid;
	bus_pkg::word_t way0_word;
	bus_pkg::word_t way1_word;

	cache_pkg::way_t lru_way;
	cache_pkg::way_t victim_way;
	cache_pkg::way_t used_way;
	logic update_en;
	logic miss;
	logic refill_busy;

	cache_pkg::way_mask_t fill_we;
	cache_pkg::way_mask_t fill_done;
	cache_pkg::index_t fill_index;
	cache_pkg::offset_t fill_offset;
	bus_pkg::word_t fill_data;
	cache_pkg::tag_t fill_tag;

	// byte bits [1:0] are not needed for word reads
	assign cpu_offset = cpu_addr[`CACHE_OFFSET_W+1:2];
	assign cpu_index = cpu_addr[`CACHE_INDEX_W+`CACHE_OFFSET_W+1:`CACHE_OFFSET_W+2];
	assign cpu_tag = cpu_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W+`CACHE_OFFSET_W+2];

	cache_way u_way0
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_index  (cpu_index),
		.lookup_offset (cpu_offset),
		.line_tag      (way0_tag),
		.line_valid    (way0_valid),
		.word          (way0_word),
		.fill_we       (fill_we[0]),
		.fill_index    (fill_index),
		.fill_offset   (fill_offset),
		.fill_data     (fill_data),
		.fill_done     (fill_done[0]),
		.fill_tag      (fill_tag)
	);

	cache_way u_way1
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_index  (cpu_index),
		.lookup_offset (cpu_offset),
		.line_tag      (way1_tag),
		.line_valid    (way1_valid),
		.word          (way1_word),
		.fill_we       (fill_we[1]),
		.fill_index    (fill_index),
		.fill_offset   (fill_offset),
		.fill_data     (fill_data),
		.fill_done     (fill_done[1]),
		.fill_tag      (fill_tag)
	);

	// hits always update the set being looked up
	lru_table u_lru
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.read_index   (cpu_index),
		.lru_way      (lru_way),
		.update_en    (update_en),
		.update_index (cpu_index),
		.used_way     (used_way)
	);

	hit_select u_hit
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_re       (cpu_re),
		.lookup_tag   (cpu_tag),
		.lookup_index (cpu_index),
		.way0_tag     (way0_tag),
		.way1_tag     (way1_tag),
		.way0_valid   (way0_valid),
		.way1_valid   (way1_valid),
		.way0_word    (way0_word),
		.way1_word    (way1_word),
		.lru_way      (lru_way),
		.refill_busy  (refill_busy),
		.miss         (miss),
		.victim_way   (victim_way),
		.cpu_stall    (cpu_stall),
		.cpu_rdata    (cpu_rdata),
		.update_en    (update_en),
		.used_way     (used_way)
	);

	refill_fsm u_refill
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.miss         (miss),
		.miss_tag     (cpu_tag),
		.miss_index   (cpu_index),
		.victim_way   (victim_way),
		.refill_busy  (refill_busy),
		.bus_req      (bus_req),
		.bus_grant    (bus_grant),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready),
		.fill_we      (fill_we),
		.fill_index   (fill_index),
		.fill_offset  (fill_offset),
		.fill_data    (fill_data),
		.fill_done    (fill_done),
		.fill_tag     (fill_tag)
	);

endmodule

`default_nettype wire

/* source/lru_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module lru_table
(
	input  logic              clk,
	input  logic              rst_n,
	// victim lookup
	input  cache_pkg::index_t read_index,
	output cache_pkg::way_t   lru_way,
	// hit update
	input  logic              update_en,
	input  cache_pkg::index_t update_index,
	input  cache_pkg::way_t   used_way
);

	// one bit per set, naming the way to replace next
	logic [`CACHE_SETS-1:0] lru_q;

	assign lru_way = lru_q[read_index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lru_q <= '0;
		end
		else if (update_en)
		begin
			// point at the way that was not just used
			lru_q[update_index] <= ~used_way;
		end
	end

endmodule

`default_nettype wire

/* source/refill_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module refill_fsm
(
	input  logic                 clk,
	input  logic                 rst_n,
	// miss from the lookup
	input  logic                 miss,
	input  cache_pkg::tag_t      miss_tag,
	input  cache_pkg::index_t    miss_index,
	input  cache_pkg::way_t      victim_way,
	output logic                 refill_busy,
	// bus arbitration
	output logic                 bus_req,
	input  logic                 bus_grant,
	// read address channel
	output logic                 arvalid,
	output bus_pkg::addr_t       araddr,
	input  logic                 arready,
	// read data channel
	input  bus_pkg::word_t       rdata,
	input  logic                 rvalid,
	output logic                 rready,
	// way fill
	output cache_pkg::way_mask_t fill_we,
	output cache_pkg::index_t    fill_index,
	output cache_pkg::offset_t   fill_offset,
	output bus_pkg::word_t       fill_data,
	output cache_pkg::way_mask_t fill_done,
	output cache_pkg::tag_t      fill_tag
);

	cache_pkg::refill_state_t state_q;
	cache_pkg::tag_t tag_q;
	cache_pkg::index_t index_q;
	cache_pkg::way_t victim_q;
	bus_pkg::beat_count_t beat_q;
	cache_pkg::way_mask_t victim_mask;
	logic beat;
	logic last_beat;

	assign refill_busy = (state_q != cache_pkg::st_idle);

	// line aligned burst address
	assign araddr = {tag_q, index_q, {`CACHE_OFFSET_W{1'b0}}, 2'b00};

	assign beat = (state_q == cache_pkg::st_data) && rvalid;
	assign last_beat = beat && (beat_q == bus_pkg::beat_count_t'(`CACHE_BURST_BEATS - 1));

	assign victim_mask = {victim_q, ~victim_q};
	assign fill_we = beat ? victim_mask : 2'b00;
	assign fill_done = last_beat ? victim_mask : 2'b00;
	assign fill_index = index_q;
	assign fill_offset = cache_pkg::offset_t'(beat_q);
	assign fill_data = rdata;
	assign fill_tag = tag_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= cache_pkg::st_idle;
			bus_req <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
		end
		else
		begin
			case (state_q)
				cache_pkg::st_idle:
				begin
					if (miss)
					begin
						bus_req <= 1'b1;
						state_q <= cache_pkg::st_bus_wait;
					end
				end
				cache_pkg::st_bus_wait:
				begin
					if (bus_grant)
					begin
						arvalid <= 1'b1;
						state_q <= cache_pkg::st_addr;
					end
				end
				cache_pkg::st_addr:
				begin
					// address taken, open the data channel
					if (arready)
					begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						state_q <= cache_pkg::st_data;
					end
				end
				cache_pkg::st_data:
				begin
					if (last_beat)
					begin
						rready <= 1'b0;
						bus_req <= 1'b0;
						state_q <= cache_pkg::st_settle;
					end
				end
				cache_pkg::st_settle:
				begin
					state_q <= cache_pkg::st_idle;
				end
				default:
				begin
					state_q <= cache_pkg::st_idle;
				end
			endcase
		end
	end

	// miss line and victim held for the whole refill
	always_ff @(posedge clk)
	begin
		if ((state_q == cache_pkg::st_idle) && miss)
		begin
			tag_q <= miss_tag;
			index_q <= miss_index;
			victim_q <= victim_way;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == cache_pkg::st_addr)
		begin
			beat_q <= '0;
		end
		else if (beat)
		begin
			beat_q <= beat_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verif/icache_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module icache_checker
(
	input  logic           clk,
	input  logic           rst_n,
	// cpu side of the DUT
	input  logic           cpu_re,
	input  bus_pkg::addr_t cpu_addr,
	input  logic           cpu_stall,
	input  bus_pkg::word_t cpu_rdata,
	// bus side of the DUT
	input  logic           bus_req,
	input  logic           arvalid,
	input  bus_pkg::addr_t araddr,
	input  logic           arready,
	input  logic           rvalid,
	input  logic           rready,
	// expectation for the row being presented
	input  int             row,
	input  bus_pkg::word_t exp_word,
	input  logic           exp_miss,
	output int             error_count,
	output int             rows_done,
	output int             rows_failed
);

	logic reset_seen;
	logic bus_req_q;
	logic stall_flagged;
	logic pending;
	int rises;
	int beats;
	int row_errors;
	int pend_row;
	int pend_rises;
	int pend_beats;
	logic pend_miss;
	bus_pkg::addr_t pend_addr;
	bus_pkg::word_t pend_word;

	function automatic bus_pkg::addr_t line_base(input bus_pkg::addr_t addr);
		return {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+2], {(`CACHE_OFFSET_W+2){1'b0}}};
	endfunction

	// word, request count and beat count of the row accepted last cycle
	task automatic close_row();
		if (cpu_rdata !== pend_word)
		begin
			$display("Error at %0t ns: row %0d read %h, expected %h",
				$time, pend_row, cpu_rdata, pend_word);
			row_errors++;
		end
		if (pend_rises != (pend_miss ? 1 : 0))
		begin
			$display("Error at %0t ns: row %0d saw %0d bus requests, expected %0d",
				$time, pend_row, pend_rises, pend_miss ? 1 : 0);
			row_errors++;
		end
		if (pend_beats != (pend_miss ? `CACHE_BURST_BEATS : 0))
		begin
			$display("Error at %0t ns: row %0d took %0d beats", $time, pend_row, pend_beats);
			row_errors++;
		end
		$display("row %0d addr %h miss %0d: %s", pend_row, pend_addr, pend_miss,
			(row_errors == 0) ? "pass" : "fail");
		rows_done++;
		if (row_errors != 0)
		begin
			rows_failed++;
		end
		error_count += row_errors;
		row_errors = 0;
		pending = 1'b0;
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			reset_seen = 1'b0;
			bus_req_q = 1'b0;
			stall_flagged = 1'b0;
			pending = 1'b0;
			rises = 0;
			beats = 0;
			row_errors = 0;
			error_count = 0;
			rows_done = 0;
			rows_failed = 0;
		end
		else
		begin
			// first cycle out of reset, cpu_re still low
			if (!reset_seen)
			begin
				reset_seen = 1'b1;
				if (bus_req || arvalid || rready || cpu_stall)
				begin
					$display("Error at %0t ns: bus outputs or stall not low after reset", $time);
					error_count++;
				end
			end
			if (pending)
			begin
				close_row();
			end
			if (bus_req && !bus_req_q)
			begin
				rises++;
			end
			bus_req_q = bus_req;
			if (rvalid && rready)
			begin
				beats++;
			end
			// burst must start at the line holding the held cpu address
			if (arvalid && arready && (araddr != line_base(cpu_addr)))
			begin
				$display("Error at %0t ns: araddr %h, expected %h",
					$time, araddr, line_base(cpu_addr));
				row_errors++;
			end
			if (cpu_re && cpu_stall && !exp_miss && !stall_flagged)
			begin
				$display("Error at %0t ns: row %0d stalled on an expected hit", $time, row);
				stall_flagged = 1'b1;
				row_errors++;
			end
			if (cpu_re && !cpu_stall)
			begin
				pending = 1'b1;
				pend_row = row;
				pend_addr = cpu_addr;
				pend_word = exp_word;
				pend_miss = exp_miss;
				pend_rises = rises;
				pend_beats = beats;
				rises = 0;
				beats = 0;
				stall_flagged = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_cfg.svh"

module icache_tb;

	localparam int NUM_ROWS = 21;
	localparam int CYCLE_LIMIT = NUM_ROWS * (`CACHE_BURST_BEATS * 4 + 20);
	localparam bus_pkg::word_t MEM_KEY = 32'hA5A5_0000;

	logic clk;
	logic rst_n;
	logic cpu_re;
	bus_pkg::addr_t cpu_addr;
	logic cpu_stall;
	bus_pkg::word_t cpu_rdata;
	logic bus_req;
	logic bus_grant;
	logic arvalid;
	bus_pkg::addr_t araddr;
	logic arready;
	bus_pkg::word_t rdata;
	logic rvalid;
	logic rready;

	// stimulus table
	bus_pkg::addr_t row_addr [NUM_ROWS];
	bus_pkg::word_t row_word [NUM_ROWS];
	logic row_miss [NUM_ROWS];

	int row;
	bus_pkg::word_t exp_word;
	logic exp_miss;
	int error_count;
	int rows_done;
	int rows_failed;
	int cycles;
	integer seed = 88;

	// memory slave state
	bus_pkg::addr_t burst_addr;
	int beats_left;
	int grant_delay;
	int addr_delay;
	int beat_delay;
	logic grant_armed;
	logic addr_armed;
	logic beat_armed;

	icache_top UUT
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_re    (cpu_re),
		.cpu_addr  (cpu_addr),
		.cpu_stall (cpu_stall),
		.cpu_rdata (cpu_rdata),
		.bus_req   (bus_req),
		.bus_grant (bus_grant),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arready   (arready),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.rready    (rready)
	);

	icache_checker u_checker
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_re      (cpu_re),
		.cpu_addr    (cpu_addr),
		.cpu_stall   (cpu_stall),
		.cpu_rdata   (cpu_rdata),
		.bus_req     (bus_req),
		.arvalid     (arvalid),
		.araddr      (araddr),
		.arready     (arready),
		.rvalid      (rvalid),
		.rready      (rready),
		.row         (row),
		.exp_word    (exp_word),
		.exp_miss    (exp_miss),
		.error_count (error_count),
		.rows_done   (rows_done),
		.rows_failed (rows_failed)
	);

	function automatic bus_pkg::word_t mem_word(input bus_pkg::addr_t addr);
		return addr ^ MEM_KEY;
	endfunction

	function automatic int pick_delay();
		return int'($unsigned($random(seed)) % 32'd4);
	endfunction

	task automatic set_row(input int i, input bus_pkg::addr_t addr, input logic miss);
		row_addr[i] = addr;
		row_word[i] = mem_word(addr);
		row_miss[i] = miss;
	endtask

	// miss flags follow the victim and lru rules, set 0 unless noted
	task automatic load_table();
		set_row(0, 32'h0000_1000, 1'b1);
		set_row(1, 32'h0000_1004, 1'b0);
		set_row(2, 32'h0000_1008, 1'b0);
		set_row(3, 32'h0000_103C, 1'b0);
		// second tag goes to way 1
		set_row(4, 32'h0000_2010, 1'b1);
		set_row(5, 32'h0000_1020, 1'b0);
		set_row(6, 32'h0000_2024, 1'b0);
		// third tag evicts way 0, tag 8 survives
		set_row(7, 32'h0000_3008, 1'b1);
		set_row(8, 32'h0000_2000, 1'b0);
		set_row(9, 32'h0000_1000, 1'b1);
		set_row(10, 32'h0000_3000, 1'b1);
		set_row(11, 32'h0000_1004, 1'b0);
		set_row(12, 32'h0000_2004, 1'b1);
		// set 1
		set_row(13, 32'h0000_0440, 1'b1);
		set_row(14, 32'h0000_0444, 1'b0);
		set_row(15, 32'h0000_0448, 1'b0);
		set_row(16, 32'h0000_1000, 1'b0);
		// set 15, last word of the line first
		set_row(17, 32'h0000_7FFC, 1'b1);
		set_row(18, 32'h0000_7FC0, 1'b0);
		set_row(19, 32'hABCD_0040, 1'b1);
		set_row(20, 32'h0000_0440, 1'b0);
	endtask

	task automatic wait_accept();
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(posedge clk);
			accepted = cpu_re && !cpu_stall;
		end
	endtask

	// one step of the slave, grant then address then beats
	task automatic serve_bus();
		if (!bus_req)
		begin
			bus_grant = 1'b0;
			grant_armed = 1'b0;
		end
		else if (!bus_grant)
		begin
			if (!grant_armed)
			begin
				grant_delay = pick_delay();
				grant_armed = 1'b1;
			end
			if (grant_delay == 0)
			begin
				bus_grant = 1'b1;
			end
			else
			begin
				grant_delay--;
			end
		end
		if (arvalid && !arready)
		begin
			if (!addr_armed)
			begin
				addr_delay = pick_delay();
				addr_armed = 1'b1;
			end
			if (addr_delay == 0)
			begin
				arready = 1'b1;
				addr_armed = 1'b0;
				burst_addr = araddr;
				beats_left = `CACHE_BURST_BEATS;
			end
			else
			begin
				addr_delay--;
			end
		end
		else
		begin
			arready = 1'b0;
		end
		// a beat shown last cycle was taken, rready was high
		if (rvalid)
		begin
			rvalid = 1'b0;
			burst_addr += 4;
			beats_left--;
		end
		if (rready && (beats_left > 0))
		begin
			if (!beat_armed)
			begin
				beat_delay = pick_delay();
				beat_armed = 1'b1;
			end
			if (beat_delay == 0)
			begin
				rvalid = 1'b1;
				rdata = mem_word(burst_addr);
				beat_armed = 1'b0;
			end
			else
			begin
				beat_delay--;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	initial
	begin
		bus_grant = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		burst_addr = '0;
		beats_left = 0;
		grant_delay = 0;
		addr_delay = 0;
		beat_delay = 0;
		grant_armed = 1'b0;
		addr_armed = 1'b0;
		beat_armed = 1'b0;
		forever
		begin
			@(negedge clk);
			serve_bus();
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles, %0d of %0d rows done",
			cycles, rows_done, NUM_ROWS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_addr = '0;
		row = 0;
		exp_word = '0;
		exp_miss = 1'b0;
		load_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			row = i;
			cpu_re = 1'b1;
			cpu_addr = row_addr[i];
			exp_word = row_word[i];
			exp_miss = row_miss[i];
			wait_accept();
			@(negedge clk);
		end
		cpu_re = 1'b0;
		while (rows_done < NUM_ROWS)
		begin
			@(posedge clk);
		end
		$display("rows %0d, failed %0d, errors %0d", rows_done, rows_failed, error_count);
		if ((error_count == 0) && (rows_failed == 0))
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
